// File: hdl/lsu_axi_master.sv
`timescale 1ns/1ps

module lsu_axi_master import lsu_pkg::*; #(
    parameter int addr_width = 32
) (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    // LSU side
    input  logic                    req,
    input  logic                    we,
    input  lsu_size_t               size,
    input  logic                    load_signed,
    input  logic [addr_width-1:0]   addr,
    input  logic [data_width-1:0]   wdata,
    output logic                    ack,
    output logic [data_width-1:0]   rdata,
    output logic                    err,
    // AXI4-Lite master side
    output logic [addr_width-1:0]   m_awaddr,
    output logic                    m_awvalid,
    input  logic                    m_awready,
    output logic [data_width-1:0]   m_wdata,
    output logic [data_width/8-1:0] m_wstrb,
    output logic                    m_wvalid,
    input  logic                    m_wready,
    input  axi_resp_t               m_bresp,
    input  logic                    m_bvalid,
    output logic                    m_bready,
    output logic [addr_width-1:0]   m_araddr,
    output logic                    m_arvalid,
    input  logic                    m_arready,
    input  logic [data_width-1:0]   m_rdata,
    input  axi_resp_t               m_rresp,
    input  logic                    m_rvalid,
    output logic                    m_rready
);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_write = 2'd1;
    localparam logic [1:0] st_read  = 2'd2;
    localparam logic [1:0] st_done  = 2'd3;

    logic [1:0]              state;
    lsu_word_u               st_lanes;
    logic [data_width/8-1:0] st_strb;
    logic [data_width-1:0]   ld_value;

    // --------------------
    // store lanes
    // --------------------

    // data copied into every lane, the strobe picks the live one
    always_comb
    begin
        case (size)
            size_byte:
            begin
                st_lanes.bytes = {4{wdata[7:0]}};
                st_strb        = 4'b0001 << addr[1:0];
            end
            size_half:
            begin
                st_lanes.halves = {2{wdata[15:0]}};
                st_strb         = 4'b0011 << {addr[1], 1'b0};
            end
            default:
            begin
                st_lanes = wdata;
                st_strb  = 4'b1111;
            end
        endcase
    end

    // offset, size and sign are still held by the core at the R handshake
    lsu_load_align u_align (
        .word        (m_rdata),
        .offset      (addr[1:0]),
        .size        (size),
        .load_signed (load_signed),
        .value       (ld_value)
    );

    // --------------------
    // control FSM
    // --------------------

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state     <= st_idle;
            ack       <= 1'b0;
            m_awvalid <= 1'b0;
            m_wvalid  <= 1'b0;
            m_bready  <= 1'b0;
            m_arvalid <= 1'b0;
            m_rready  <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    // address and data valids go up together for stores
                    if (req && !ack)
                    begin
                        m_awvalid <= we;
                        m_wvalid  <= we;
                        m_bready  <= we;
                        m_arvalid <= ~we;
                        m_rready  <= ~we;
                        state     <= we ? st_write : st_read;
                    end
                end
                st_write:
                begin
                    if (m_awready)
                    begin
                        m_awvalid <= 1'b0;
                    end
                    if (m_wready)
                    begin
                        m_wvalid <= 1'b0;
                    end
                    if (m_bvalid)
                    begin
                        m_bready <= 1'b0;
                        ack      <= 1'b1;
                        state    <= st_done;
                    end
                end
                st_read:
                begin
                    if (m_arready)
                    begin
                        m_arvalid <= 1'b0;
                    end
                    if (m_rvalid)
                    begin
                        m_rready <= 1'b0;
                        ack      <= 1'b1;
                        state    <= st_done;
                    end
                end
                default:
                begin
                    // hold ack until the core drops req
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // --------------------
    // payload
    // --------------------

    // bus address is always word aligned
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (state == st_idle && req && !ack)
        begin
            m_awaddr <= {addr[addr_width-1:2], 2'b00};
            m_araddr <= {addr[addr_width-1:2], 2'b00};
            m_wdata  <= st_lanes;
            m_wstrb  <= st_strb;
        end
        if (state == st_write && m_bvalid)
        begin
            err <= m_bresp != resp_okay;
        end
        if (state == st_read && m_rvalid)
        begin
            // slave already zeroes data on slverr
            rdata <= ld_value;
            err   <= m_rresp != resp_okay;
        end
    end

endmodule

// File: hdl/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*; (
    input  logic [data_width-1:0] word,
    input  logic [1:0]            offset,
    input  lsu_size_t             size,
    input  logic                  load_signed,
    output logic [data_width-1:0] value
);

    lsu_word_u  lanes;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // same word, picked apart two ways
    assign lanes     = word;
    assign byte_lane = lanes.bytes[offset];
    // halfword lane only looks at the upper offset bit
    assign half_lane = lanes.halves[offset[1]];

    // --------------------
    // extension
    // --------------------

    // lb/lbu and lh/lhu differ only in the fill bit
    always_comb
    begin
        case (size)
            size_byte:
            begin
                value = {{24{load_signed & byte_lane[7]}}, byte_lane};
            end
            size_half:
            begin
                value = {{16{load_signed & half_lane[15]}}, half_lane};
            end
            default:
            begin
                // lw, nothing to shift
                value = lanes;
            end
        endcase
    end

endmodule

// File: hdl/lsu_mem_top.sv
`timescale 1ns/1ps

module lsu_mem_top import lsu_pkg::*; #(
    parameter int addr_width = 32,
    parameter int mem_words  = 256
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic                  req,
    input  logic                  we,
    input  lsu_size_t             size,
    input  logic                  load_signed,
    input  logic [addr_width-1:0] addr,
    input  logic [data_width-1:0] wdata,
    output logic                  ack,
    output logic [data_width-1:0] rdata,
    output logic                  err
);

    // --------------------
    // AXI4-Lite wires
    // --------------------

    logic [addr_width-1:0]   axi_awaddr;
    logic                    axi_awvalid;
    logic                    axi_awready;
    logic [data_width-1:0]   axi_wdata;
    logic [data_width/8-1:0] axi_wstrb;
    logic                    axi_wvalid;
    logic                    axi_wready;
    axi_resp_t               axi_bresp;
    logic                    axi_bvalid;
    logic                    axi_bready;
    logic [addr_width-1:0]   axi_araddr;
    logic                    axi_arvalid;
    logic                    axi_arready;
    logic [data_width-1:0]   axi_rdata;
    axi_resp_t               axi_rresp;
    logic                    axi_rvalid;
    logic                    axi_rready;

    // request side, one transaction per LSU access
    lsu_axi_master #(
        .addr_width (addr_width)
    ) u_master (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req           (req),
        .we            (we),
        .size          (size),
        .load_signed   (load_signed),
        .addr          (addr),
        .wdata         (wdata),
        .ack           (ack),
        .rdata         (rdata),
        .err           (err),
        .m_awaddr      (axi_awaddr),
        .m_awvalid     (axi_awvalid),
        .m_awready     (axi_awready),
        .m_wdata       (axi_wdata),
        .m_wstrb       (axi_wstrb),
        .m_wvalid      (axi_wvalid),
        .m_wready      (axi_wready),
        .m_bresp       (axi_bresp),
        .m_bvalid      (axi_bvalid),
        .m_bready      (axi_bready),
        .m_araddr      (axi_araddr),
        .m_arvalid     (axi_arvalid),
        .m_arready     (axi_arready),
        .m_rdata       (axi_rdata),
        .m_rresp       (axi_rresp),
        .m_rvalid      (axi_rvalid),
        .m_rready      (axi_rready)
    );

    // memory side, SRAM behind the slave
    sram_lsu_axi #(
        .addr_width (addr_width),
        .mem_words  (mem_words)
    ) u_slave (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (axi_awaddr),
        .S_AXI_AWVALID (axi_awvalid),
        .S_AXI_AWREADY (axi_awready),
        .S_AXI_WDATA   (axi_wdata),
        .S_AXI_WSTRB   (axi_wstrb),
        .S_AXI_WVALID  (axi_wvalid),
        .S_AXI_WREADY  (axi_wready),
        .S_AXI_BRESP   (axi_bresp),
        .S_AXI_BVALID  (axi_bvalid),
        .S_AXI_BREADY  (axi_bready),
        .S_AXI_ARADDR  (axi_araddr),
        .S_AXI_ARVALID (axi_arvalid),
        .S_AXI_ARREADY (axi_arready),
        .S_AXI_RDATA   (axi_rdata),
        .S_AXI_RRESP   (axi_rresp),
        .S_AXI_RVALID  (axi_rvalid),
        .S_AXI_RREADY  (axi_rready)
    );

endmodule

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    // --------------------
    // data path
    // --------------------

    // bus and SRAM word width, fixed by the lane union below
    localparam int data_width = 32;

    // --------------------
    // access size
    // --------------------

    // encoded like funct3[1:0] of the RISC-V load/store opcodes
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } lsu_size_t;

    // --------------------
    // AXI response
    // --------------------

    // only the two codes this subsystem ever returns
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    // --------------------
    // data word lanes
    // --------------------

    // one bus word, seen either as byte lanes or as halfword lanes
    // lane 0 is the least significant, as on a little-endian bus
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } lsu_word_u;

endpackage

// File: hdl/sram_array.sv
`timescale 1ns/1ps

module sram_array import lsu_pkg::*; #(
    parameter int mem_words = 256,
    localparam int idx_width = $clog2(mem_words)
) (
    input  logic                    S_AXI_ACLK,
    input  logic                    en,
    input  logic [data_width/8-1:0] wmask,
    input  logic [idx_width-1:0]    index,
    input  logic [data_width-1:0]   wdata,
    output logic [data_width-1:0]   rdata
);

    // word storage, contents undefined after power-up
    logic [data_width-1:0] mem [mem_words];

    // --------------------
    // access port
    // --------------------

    // a nonzero mask means a write, an empty mask means a read
    // read data shows up one cycle after the enable
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (en)
        begin
            if (|wmask)
            begin
                // only the selected byte lanes are touched
                for (int i = 0; i < data_width / 8; i++)
                begin
                    if (wmask[i])
                    begin
                        mem[index][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
            else
            begin
                rdata <= mem[index];
            end
        end
    end

endmodule

// File: hdl/sram_lsu_axi.sv
`timescale 1ns/1ps

module sram_lsu_axi import lsu_pkg::*; #(
    parameter int addr_width = 32,
    parameter int mem_words  = 256
) (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    // write address channel
    input  logic [addr_width-1:0]   S_AXI_AWADDR,
    input  logic                    S_AXI_AWVALID,
    output logic                    S_AXI_AWREADY,
    // write data channel
    input  logic [data_width-1:0]   S_AXI_WDATA,
    input  logic [data_width/8-1:0] S_AXI_WSTRB,
    input  logic                    S_AXI_WVALID,
    output logic                    S_AXI_WREADY,
    // write response channel
    output axi_resp_t               S_AXI_BRESP,
    output logic                    S_AXI_BVALID,
    input  logic                    S_AXI_BREADY,
    // read address channel
    input  logic [addr_width-1:0]   S_AXI_ARADDR,
    input  logic                    S_AXI_ARVALID,
    output logic                    S_AXI_ARREADY,
    // read data channel
    output logic [data_width-1:0]   S_AXI_RDATA,
    output axi_resp_t               S_AXI_RRESP,
    output logic                    S_AXI_RVALID,
    input  logic                    S_AXI_RREADY
);

    localparam int idx_width = $clog2(mem_words);

    logic aw_en;
    logic wr_fire;
    logic wr_ok;
    logic rd_fire;
    logic rd_ok;
    logic rd_pend;
    logic rd_ok_q;

    logic                    sram_en;
    logic [data_width/8-1:0] sram_wmask;
    logic [idx_width-1:0]    sram_index;
    logic [data_width-1:0]   sram_rdata;

    // --------------------
    // range check
    // --------------------

    // word index of each address against the SRAM depth
    assign wr_ok = S_AXI_AWADDR[addr_width-1:2] < mem_words;
    assign rd_ok = S_AXI_ARADDR[addr_width-1:2] < mem_words;

    // address and data are taken in the same cycle
    assign wr_fire = S_AXI_AWREADY & S_AXI_AWVALID & S_AXI_WREADY & S_AXI_WVALID
                   & ~S_AXI_BVALID;
    assign rd_fire = S_AXI_ARREADY & S_AXI_ARVALID;

    // --------------------
    // write path
    // --------------------

    // both readies pulse together once both valids are up
    // aw_en blocks a second write until the response is taken
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
            aw_en         <= 1'b1;
        end
        else if (~S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en)
        begin
            S_AXI_AWREADY <= 1'b1;
            S_AXI_WREADY  <= 1'b1;
            aw_en         <= 1'b0;
        end
        else
        begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_WREADY  <= 1'b0;
            if (S_AXI_BREADY && S_AXI_BVALID)
            begin
                aw_en <= 1'b1;
            end
        end
    end

    // response comes up the cycle after the SRAM write
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            S_AXI_BVALID <= 1'b0;
        end
        else if (wr_fire)
        begin
            S_AXI_BVALID <= 1'b1;
        end
        else if (S_AXI_BREADY && S_AXI_BVALID)
        begin
            S_AXI_BVALID <= 1'b0;
        end
    end

    // out of range stores are dropped and flagged
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr_fire)
        begin
            S_AXI_BRESP <= wr_ok ? resp_okay : resp_slverr;
        end
    end

    // --------------------
    // read path
    // --------------------

    // one read in flight, held off while data waits on rready
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            S_AXI_ARREADY <= 1'b0;
            rd_pend       <= 1'b0;
            S_AXI_RVALID  <= 1'b0;
        end
        else
        begin
            S_AXI_ARREADY <= ~S_AXI_ARREADY & S_AXI_ARVALID & ~S_AXI_RVALID & ~rd_pend;
            // SRAM word is being fetched this cycle
            rd_pend <= rd_fire;
            if (rd_pend)
            begin
                S_AXI_RVALID <= 1'b1;
            end
            else if (S_AXI_RVALID && S_AXI_RREADY)
            begin
                S_AXI_RVALID <= 1'b0;
            end
        end
    end

    // range result follows the fetch, data is zeroed when out of range
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_fire)
        begin
            rd_ok_q <= rd_ok;
        end
        if (rd_pend)
        begin
            S_AXI_RDATA <= rd_ok_q ? sram_rdata : '0;
            S_AXI_RRESP <= rd_ok_q ? resp_okay : resp_slverr;
        end
    end

    // --------------------
    // SRAM port
    // --------------------

    // writes take the port when both sides collide
    assign sram_en    = (wr_fire & wr_ok) | (rd_fire & rd_ok);
    assign sram_wmask = (wr_fire & wr_ok) ? S_AXI_WSTRB : '0;
    assign sram_index = wr_fire ? S_AXI_AWADDR[idx_width+1:2] : S_AXI_ARADDR[idx_width+1:2];

    sram_array #(
        .mem_words (mem_words)
    ) u_sram (
        .S_AXI_ACLK (S_AXI_ACLK),
        .en         (sram_en),
        .wmask      (sram_wmask),
        .index      (sram_index),
        .wdata      (S_AXI_WDATA),
        .rdata      (sram_rdata)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic S_AXI_ACLK,
    output logic S_AXI_ARESETN
);

    // 40 ns period
    initial
    begin
        S_AXI_ACLK = 1'b0;
        forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // reset held low over three rising edges, released just after the third
    initial
    begin
        S_AXI_ARESETN = 1'b0;
        repeat (3) @(posedge S_AXI_ACLK);
        #2 S_AXI_ARESETN = 1'b1;
    end

endmodule

// File: sim/tb_lsu_mem.sv
`timescale 1ns/1ps

module tb_lsu_mem import lsu_pkg::*;;

    localparam int mem_words  = 256;
    localparam int n_directed = 41;
    localparam int n_random   = 200;
    // every access finishes well inside 16 cycles
    localparam int timeout_cycles = (mem_words + n_directed + n_random) * 16 + 100;

    logic        S_AXI_ACLK;
    logic        S_AXI_ARESETN;
    logic        req;
    logic        we;
    lsu_size_t   size;
    logic        load_signed;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        ack;
    logic [31:0] rdata;
    logic        err;

    // expectations for the access in flight
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic        chk_rdata;

    // byte-wide reference copy of the SRAM
    logic [7:0]  ref_mem [mem_words*4];
    logic [31:0] lcg_state;
    int unsigned cycles;

    tb_clock_gen clk_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN)
    );

    lsu_mem_top #(
        .addr_width (32),
        .mem_words  (mem_words)
    ) dut0 (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .req           (req),
        .we            (we),
        .size          (size),
        .load_signed   (load_signed),
        .addr          (addr),
        .wdata         (wdata),
        .ack           (ack),
        .rdata         (rdata),
        .err           (err)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    // --------------------
    // checks
    // --------------------

    // ack cleared by reset
    ack_reset: assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=> !ack)
    else
        report_failure($sformatf("FAILED at %0t ns: ack expected 0, actual %0b",
                                 $time, ack));

    // ack only answers a req that was high when it was raised
    ack_rise: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(ack) |-> $past(req))
    else
        report_failure($sformatf("ack rose while req was low at %0t ns", $time));

    // ack drops only once req was seen low
    ack_fall: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $fell(ack) |-> !$past(req))
    else
        report_failure($sformatf("ack fell while req was still high at %0t ns", $time));

    err_value: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $rose(ack) |-> err == exp_err)
    else
        report_failure($sformatf("FAILED at %0t ns: err expected %0b, actual %0b",
                                 $time, exp_err, err));

    // only loads return data
    rdata_value: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        ($rose(ack) && chk_rdata) |-> rdata == exp_rdata)
    else
        report_failure($sformatf("FAILED at %0t ns: rdata expected %08h, actual %08h",
                                 $time, exp_rdata, rdata));

    // hang guard
    always @(posedge S_AXI_ACLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
        begin
            report_failure("simulation timed out waiting for the DUT");
        end
    end

    // --------------------
    // reference model
    // --------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // initial contents hash the full byte address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ (a >> 3) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] a);
        logic [31:0] base;
        base = {a[31:2], 2'b00};
        return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    endfunction

    // little-endian lane then sign or zero fill
    function automatic logic [31:0] expected_load(input lsu_size_t sz, input logic sgn,
                                                  input logic [31:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        case (sz)
            size_byte:
            begin
                b = ref_mem[a];
                return {{24{sgn & b[7]}}, b};
            end
            size_half:
            begin
                h = {ref_mem[{a[31:1], 1'b1}], ref_mem[{a[31:1], 1'b0}]};
                return {{16{sgn & h[15]}}, h};
            end
            default:
            begin
                return model_word(a);
            end
        endcase
    endfunction

    // --------------------
    // LSU accesses
    // --------------------

    // sample 2 ns after the edge where the DUT outputs are settled
    task automatic wait_ack(input logic level);
        do
        begin
            @(posedge S_AXI_ACLK);
            #2;
        end
        while (ack !== level);
    endtask

    // one four-phase request
    task automatic run_access(input logic wr, input lsu_size_t sz, input logic sgn,
                              input logic [31:0] a, input logic [31:0] d,
                              input logic check_rdata, input logic [31:0] want_rdata,
                              input logic want_err);
        @(posedge S_AXI_ACLK);
        #2;
        exp_rdata   = want_rdata;
        exp_err     = want_err;
        chk_rdata   = check_rdata;
        we          = wr;
        size        = sz;
        load_signed = sgn;
        addr        = a;
        wdata       = d;
        req         = 1'b1;
        wait_ack(1'b1);
        req = 1'b0;
        wait_ack(1'b0);
    endtask

    // out of range stores leave the model untouched
    task automatic write_mem(input lsu_size_t sz, input logic [31:0] a, input logic [31:0] d);
        logic in_range;
        in_range = a[31:2] < mem_words;
        if (in_range)
        begin
            case (sz)
                size_byte:
                begin
                    ref_mem[a] = d[7:0];
                end
                size_half:
                begin
                    ref_mem[{a[31:1], 1'b0}] = d[7:0];
                    ref_mem[{a[31:1], 1'b1}] = d[15:8];
                end
                default:
                begin
                    for (int k = 0; k < 4; k++)
                    begin
                        ref_mem[{a[31:2], 2'b00} + k] = d[8*k +: 8];
                    end
                end
            endcase
        end
        run_access(1'b1, sz, 1'b0, a, d, 1'b0, '0, !in_range);
    endtask

    task automatic read_mem(input lsu_size_t sz, input logic sgn, input logic [31:0] a);
        logic        in_range;
        logic [31:0] want;
        in_range = a[31:2] < mem_words;
        if (in_range)
        begin
            want = expected_load(sz, sgn, a);
        end
        else
        begin
            // slverr load returns zero
            want = '0;
        end
        run_access(1'b0, sz, sgn, a, '0, 1'b1, want, !in_range);
    endtask

    // --------------------
    // stimulus
    // --------------------

    initial
    begin
        logic [31:0] r;
        logic [31:0] a;
        lsu_size_t   sz;
        int          pick;
        logic [31:0] oor_addr [4];
        lsu_size_t   oor_size [4];
        int          word_idx [3];

        req         = 1'b0;
        we          = 1'b0;
        size        = size_word;
        load_signed = 1'b0;
        addr        = '0;
        wdata       = '0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        chk_rdata   = 1'b0;
        cycles      = 0;
        lcg_state   = 32'd19;
        oor_addr    = '{32'h0000_0400, 32'h0000_0401, 32'h8000_0002, 32'hffff_fffc};
        oor_size    = '{size_word, size_byte, size_half, size_word};
        word_idx    = '{5, 100, 255};

        wait (S_AXI_ARESETN === 1'b1);

        // SRAM powers up unknown so every word is written first
        for (int i = 0; i < mem_words; i++)
        begin
            write_mem(size_word, i * 4, fill_word(i * 4));
        end

        // word store and load back
        foreach (word_idx[i])
        begin
            write_mem(size_word, word_idx[i] * 4, next_rand());
            read_mem(size_word, 1'b0, word_idx[i] * 4);
        end

        // partial stores touch only their lanes
        for (int off = 0; off < 4; off++)
        begin
            write_mem(size_byte, 40 + off, next_rand());
            read_mem(size_word, 1'b0, 40);
        end
        for (int off = 0; off < 4; off += 2)
        begin
            write_mem(size_half, 44 + off, next_rand());
            read_mem(size_word, 1'b0, 44);
        end

        // lanes with and without the top bit set
        write_mem(size_word, 48, 32'h80f1_7f01);
        for (int off = 0; off < 4; off++)
        begin
            read_mem(size_byte, 1'b0, 48 + off);
            read_mem(size_byte, 1'b1, 48 + off);
        end
        for (int off = 0; off < 4; off += 2)
        begin
            read_mem(size_half, 1'b0, 48 + off);
            read_mem(size_half, 1'b1, 48 + off);
        end

        // these alias to words 0 and 255 in the SRAM index bits
        foreach (oor_addr[i])
        begin
            write_mem(oor_size[i], oor_addr[i], 32'hdead_beef);
            read_mem(oor_size[i], 1'b1, oor_addr[i]);
        end
        read_mem(size_word, 1'b0, 0);
        read_mem(size_word, 1'b0, (mem_words - 1) * 4);

        // random mix of accesses in range and aligned to size
        for (int n = 0; n < n_random; n++)
        begin
            r    = next_rand();
            pick = int'(r[29:28]) % 3;
            case (pick)
                0: sz = size_byte;
                1: sz = size_half;
                default: sz = size_word;
            endcase
            a = next_rand() % (mem_words * 4);
            if (sz == size_half)
            begin
                a[0] = 1'b0;
            end
            else if (sz == size_word)
            begin
                a[1:0] = 2'b00;
            end
            if (r[31])
            begin
                write_mem(sz, a, next_rand());
            end
            else
            begin
                read_mem(sz, r[27], a);
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: vlog.f
hdl/lsu_pkg.sv
hdl/sram_array.sv
hdl/sram_lsu_axi.sv
hdl/lsu_load_align.sv
hdl/lsu_axi_master.sv
hdl/lsu_mem_top.sv
sim/tb_clock_gen.sv
sim/tb_lsu_mem.sv
